// ==== common/board_pkg.sv ====
package board_pkg;

    // side length of the square board.
    localparam int BOARD_SIZE = 15;

    // stone code of one cell. 2'd3 is never legal.
    typedef enum logic [1:0] {
        CELL_BLACK = 2'd0,
        CELL_WHITE = 2'd1,
        CELL_EMPTY = 2'd2
    } cell_e;

    // bit view of the same code.
    typedef struct packed {
        logic empty; // no stone.
        logic white; // stone colour when not empty.
    } cell_bits_t;

    // one cell seen either as a stone code or as two flags.
    // the matcher uses the flags so a single compare covers either color.
    typedef union packed {
        cell_e      kind;
        cell_bits_t bits;
    } cell_u;

endpackage

// ==== common/score_pkg.sv ====
package score_pkg;

    // hit flag positions, one per kept pattern.
    typedef enum logic [2:0] {
        PAT_FIVE       = 3'd0,
        PAT_OPEN_FOUR  = 3'd1,
        PAT_BLK_FOUR_O = 3'd2, // open end before the four.
        PAT_BLK_FOUR_R = 3'd3, // open end after the four.
        PAT_OPEN_THREE = 3'd4,
        PAT_OPEN_TWO   = 3'd5
    } pat_e;

    localparam int N_PAT = 6;

    typedef logic [N_PAT-1:0] pat_vec_t;

    // longest kept pattern, in cells.
    localparam int MAX_PAT_LEN = 6;

    localparam logic [31:0] W_FIVE       = 32'd1000000;
    localparam logic [31:0] W_OPEN_FOUR  = 32'd100000;
    localparam logic [31:0] W_BLK_FOUR   = 32'd10000;
    localparam logic [31:0] W_OPEN_THREE = 32'd1000;
    localparam logic [31:0] W_OPEN_TWO   = 32'd100;

    localparam int SCORE_W = 32;

endpackage

// ==== gomoku_eval.f ====
common/board_pkg.sv
common/score_pkg.sv
verilog/line_feeder.sv
pattern_scan/pattern_matcher.sv
verilog/score_accumulator.sv
verilog/gomoku_eval.sv
verification/tb_clock_gen.sv
verification/gomoku_eval_tb.sv

// ==== pattern_scan/pattern_matcher.sv ====
`timescale 1ns/1ps

module pattern_matcher #(
    parameter int LINE_LEN = 15,
    parameter int POS      = 0
) (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    input  board_pkg::cell_u [LINE_LEN-1:0] i_line,
    output score_pkg::pat_vec_t             o_black_hits,
    output score_pkg::pat_vec_t             o_white_hits
);

    import board_pkg::*;
    import score_pkg::*;

    // pattern symbols, relative to the scoring color.
    localparam logic [1:0] SYM_OWN = 2'd0;
    localparam logic [1:0] SYM_OPP = 2'd1;
    localparam logic [1:0] SYM_EMP = 2'd2;

    localparam int PAT_LEN [N_PAT] = '{5, 6, 6, 6, 5, 6};

    // cells in increasing row order. unused tail is padding.
    localparam logic [1:0] PAT_SYM [N_PAT][MAX_PAT_LEN] = '{
        '{SYM_OWN, SYM_OWN, SYM_OWN, SYM_OWN, SYM_OWN, SYM_EMP},
        '{SYM_EMP, SYM_OWN, SYM_OWN, SYM_OWN, SYM_OWN, SYM_EMP},
        '{SYM_EMP, SYM_OWN, SYM_OWN, SYM_OWN, SYM_OWN, SYM_OPP},
        '{SYM_OPP, SYM_OWN, SYM_OWN, SYM_OWN, SYM_OWN, SYM_EMP},
        '{SYM_EMP, SYM_OWN, SYM_OWN, SYM_OWN, SYM_EMP, SYM_EMP},
        '{SYM_EMP, SYM_EMP, SYM_OWN, SYM_OWN, SYM_EMP, SYM_EMP}
    };

    cell_u [LINE_LEN+MAX_PAT_LEN-1:0] line_pad;
    pat_vec_t                         black_d;
    pat_vec_t                         white_d;

    function automatic logic sym_ok(cell_u c, logic [1:0] sym, logic own_white);
        case (sym)
            SYM_OWN: return !c.bits.empty && (c.bits.white == own_white);
            SYM_OPP: return !c.bits.empty && (c.bits.white != own_white);
            default: return c.bits.empty;
        endcase
    endfunction

    function automatic logic win_match(cell_u [MAX_PAT_LEN-1:0] win, int p,
                                       logic own_white);
        logic ok;
        ok = 1'b1;
        for (int k = 0; k < MAX_PAT_LEN; k++) begin
            if (k < PAT_LEN[p]) begin
                ok = ok && sym_ok(win[k], PAT_SYM[p][k], own_white);
            end
        end
        return ok;
    endfunction

    // pad past the last row so every window slice exists.
    always_comb begin
        for (int i = 0; i < MAX_PAT_LEN; i++) begin
            line_pad[LINE_LEN+i].kind = CELL_EMPTY;
        end
        line_pad[LINE_LEN-1:0] = i_line;
    end

    for (genvar p = 0; p < N_PAT; p++) begin : g_pat
        if (POS + PAT_LEN[p] <= LINE_LEN) begin : g_fit
            assign black_d[p] = win_match(line_pad[POS +: MAX_PAT_LEN], p, 1'b0);
            assign white_d[p] = win_match(line_pad[POS +: MAX_PAT_LEN], p, 1'b1);
        end else begin : g_tie
            // runs off the board here.
            assign black_d[p] = 1'b0;
            assign white_d[p] = 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_black_hits <= '0;
            o_white_hits <= '0;
        end else begin
            o_black_hits <= black_d;
            o_white_hits <= white_d;
        end
    end

    a_one_five: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_black_hits[PAT_FIVE] && o_white_hits[PAT_FIVE]));

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the gomoku_eval testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module gomoku_eval_tb \
    -f gomoku_eval.f \
    -o sim_gomoku_eval &&
./obj_dir/sim_gomoku_eval > sim.log 2>&1 &&
! grep -q "Verification failed" sim.log &&
echo "PASS" || {
    echo "FAIL, see sim.log"
    exit 1
}

// ==== verification/gomoku_eval_tb.sv ====
`timescale 1ns/1ps

module gomoku_eval_tb;

    localparam int N            = 15;
    localparam int CELLS        = N * N;
    localparam int FINISH_LIMIT = 40;
    localparam int RST_LIMIT    = 10;
    localparam int IDLE_CYCLES  = 12;
    localparam int N_RANDOM     = 20;

    logic                   clk;
    logic                   rst_n;
    logic                   i_start;
    logic [2*CELLS-1:0]     board;
    logic signed [31:0]     o_score;
    logic                   o_finish;

    logic signed [31:0]     exp_score = '0;
    logic                   scan_start = 1'b0; // accepted starts only.
    int                     errors = 0;
    int                     scans = 0;

    tb_clock_gen clock_gen_i (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    gomoku_eval gomoku_eval_i (
        .i_clk    (clk),
        .i_rst_n  (rst_n),
        .i_start  (i_start),
        .i_board  (board),
        .o_score  (o_score),
        .o_finish (o_finish)
    );

    a_reset_state: assert property (@(posedge clk) $rose(rst_n) |->
        (o_finish == 1'b0 && o_score == '0))
        else begin
            errors++;
            $display("[ERROR] o_finish = %h, o_score = %h after reset, expected 0 and 0",
                     $sampled(o_finish), $sampled(o_score));
        end

    a_score: assert property (@(posedge clk) disable iff (!rst_n)
        o_finish |-> (o_score == exp_score))
        else begin
            errors++;
            $display("[ERROR] o_score = %h, expected %h", $sampled(o_score), exp_score);
        end

    // finish follows an accepted start by a fixed 16-cycle latency.
    a_finish_time: assert property (@(posedge clk) disable iff (!rst_n)
        o_finish == $past(scan_start, 17))
        else begin
            errors++;
            $display("[ERROR] o_finish = %h, expected %h",
                     $sampled(o_finish), $past(scan_start, 17));
        end

    // cell codes: 0 black, 1 white, 2 empty.
    function automatic string pat_text(int k);
        case (k)
            0:       return "SSSSS";
            1:       return "ESSSSE";
            2:       return "ESSSSO";
            3:       return "OSSSSE";
            4:       return "ESSSE";
            default: return "EESSEE";
        endcase
    endfunction

    function automatic int pat_value(int k);
        case (k)
            0:       return 1000000;
            1:       return 100000;
            2, 3:    return 10000;
            4:       return 1000;
            default: return 100;
        endcase
    endfunction

    function automatic logic [1:0] sym_code(byte sym, logic [1:0] own);
        case (sym)
            "S":     return own;
            "O":     return (own == 2'd0) ? 2'd1 : 2'd0;
            default: return 2'd2;
        endcase
    endfunction

    function automatic int color_total(logic [2*CELLS-1:0] b, logic [1:0] own);
        int    total;
        string pat;
        logic  hit;
        total = 0;
        for (int c = 0; c < N; c++) begin
            for (int k = 0; k < 6; k++) begin
                pat = pat_text(k);
                for (int p = 0; p + pat.len() <= N; p++) begin
                    hit = 1'b1;
                    for (int i = 0; i < pat.len(); i++) begin
                        if (b[2*((p+i)*N + c) +: 2] != sym_code(pat[i], own)) hit = 1'b0;
                    end
                    if (hit) total += pat_value(k);
                end
            end
        end
        return total;
    endfunction

    function automatic int score_model(logic [2*CELLS-1:0] b);
        return color_total(b, 2'd0) - color_total(b, 2'd1);
    endfunction

    function automatic logic [2*CELLS-1:0] swap_colors(logic [2*CELLS-1:0] b);
        logic [2*CELLS-1:0] s;
        s = b;
        for (int i = 0; i < CELLS; i++) begin
            if (b[2*i +: 2] == 2'd0) s[2*i +: 2] = 2'd1;
            else if (b[2*i +: 2] == 2'd1) s[2*i +: 2] = 2'd0;
        end
        return s;
    endfunction

    // one pattern alone in column col, from row 4 down.
    function automatic logic [2*CELLS-1:0] place_pattern(int k, logic [1:0] own, int col);
        logic [2*CELLS-1:0] b;
        string              pat;
        b   = {CELLS{2'd2}};
        pat = pat_text(k);
        for (int i = 0; i < pat.len(); i++) begin
            b[2*((4+i)*N + col) +: 2] = sym_code(pat[i], own);
        end
        return b;
    endfunction

    task automatic make_random(output logic [2*CELLS-1:0] b);
        for (int i = 0; i < CELLS; i++) begin
            b[2*i +: 2] = 2'($urandom % 3);
        end
    endtask

    // dup_at > 0 sends a second start that many cycles into the scan.
    task automatic run_scan(input logic [2*CELLS-1:0] b, input int exp, input int dup_at);
        logic [2*CELLS-1:0] other;
        int                 waited;
        @(negedge clk);
        board      = b;
        exp_score  = exp;
        i_start    = 1'b1;
        scan_start = 1'b1;
        @(negedge clk);
        i_start    = 1'b0;
        scan_start = 1'b0;
        if (dup_at > 0) begin
            repeat (dup_at) @(negedge clk);
            make_random(other);
            board   = other; // must not reach the latched board.
            i_start = 1'b1;
            @(negedge clk);
            i_start = 1'b0;
        end
        waited = 0;
        while (o_finish !== 1'b1 && waited < FINISH_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (o_finish !== 1'b1) begin
            errors++;
            $display("timeout: no o_finish within %0d cycles of the start", FINISH_LIMIT);
        end
        scans++;
        repeat (IDLE_CYCLES) @(negedge clk);
    endtask

    initial begin
        logic [2*CELLS-1:0] rb;
        int                 waited;
        void'($urandom(6));
        i_start = 1'b0;
        board   = {CELLS{2'd2}};

        waited = 0;
        while (rst_n !== 1'b1 && waited < RST_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            errors++;
            $display("timeout: reset was never released");
        end
        repeat (2) @(negedge clk);

        run_scan({CELLS{2'd2}}, 0, 0);

        for (int k = 0; k < 6; k++) begin
            run_scan(place_pattern(k, 2'd0, 2*k + 1), pat_value(k), 0);
            run_scan(place_pattern(k, 2'd1, 2*k + 1), -pat_value(k), 0);
        end

        for (int n = 0; n < 3; n++) begin
            make_random(rb);
            run_scan(rb, score_model(rb), 0);
            run_scan(swap_colors(rb), -score_model(rb), 0); // sign flips with colors.
        end

        for (int n = 0; n < N_RANDOM; n++) begin
            make_random(rb);
            run_scan(rb, score_model(rb), 0);
        end

        make_random(rb);
        run_scan(rb, score_model(rb), 6);

        $display("scans run: %0d, errors: %0d", scans, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS  = 100,
    parameter int RST_CYCLES = 3
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // release away from the rising edge.
    initial begin
        o_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst_n = 1'b1;
    end

endmodule

// ==== verilog/gomoku_eval.sv ====
`timescale 1ns/1ps

module gomoku_eval #(
    parameter int LINE_LEN = board_pkg::BOARD_SIZE,
    parameter int SCORE_W  = score_pkg::SCORE_W
) (
    input  logic                                    i_clk,
    input  logic                                    i_rst_n,
    input  logic                                    i_start,
    input  board_pkg::cell_u [LINE_LEN*LINE_LEN-1:0] i_board,
    output logic signed [SCORE_W-1:0]               o_score,
    output logic                                    o_finish
);

    import board_pkg::*;
    import score_pkg::*;

    // start rows that still fit a five-cell pattern.
    localparam int N_WIN = LINE_LEN - 4;

    cell_u [LINE_LEN-1:0]  line;
    logic                  line_valid;
    logic                  line_last;
    pat_vec_t [N_WIN-1:0]  black_hits;
    pat_vec_t [N_WIN-1:0]  white_hits;

    line_feeder #(
        .LINE_LEN (LINE_LEN)
    ) line_feeder_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_board      (i_board),
        .o_line       (line),
        .o_line_valid (line_valid),
        .o_line_last  (line_last)
    );

    for (genvar w = 0; w < N_WIN; w++) begin : g_win
        pattern_matcher #(
            .LINE_LEN (LINE_LEN),
            .POS      (w)
        ) pattern_matcher_i (
            .i_clk        (i_clk),
            .i_rst_n      (i_rst_n),
            .i_line       (line),
            .o_black_hits (black_hits[w]),
            .o_white_hits (white_hits[w])
        );
    end

    score_accumulator #(
        .N_WIN   (N_WIN),
        .SCORE_W (SCORE_W)
    ) score_accumulator_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_black_hits (black_hits),
        .i_white_hits (white_hits),
        .i_line_valid (line_valid),
        .i_line_last  (line_last),
        .o_score      (o_score),
        .o_finish     (o_finish)
    );

endmodule

// ==== verilog/line_feeder.sv ====
`timescale 1ns/1ps

module line_feeder #(
    parameter int LINE_LEN = 15
) (
    input  logic                                   i_clk,
    input  logic                                   i_rst_n,
    input  logic                                   i_start,
    input  board_pkg::cell_u [LINE_LEN*LINE_LEN-1:0] i_board,
    output board_pkg::cell_u [LINE_LEN-1:0]          o_line,
    output logic                                   o_line_valid,
    output logic                                   o_line_last
);

    import board_pkg::*;

    localparam int COL_W = $clog2(LINE_LEN);

    cell_u [LINE_LEN*LINE_LEN-1:0] board_q;
    logic                          busy;
    logic [COL_W-1:0]              col;
    logic                          col_end;
    logic                          bad_cell;

    assign col_end = (col == COL_W'(LINE_LEN - 1));

    // board snapshot, only taken when idle.
    always_ff @(posedge i_clk) begin
        if (i_start && !busy) begin
            board_q <= i_board;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            busy <= 1'b0;
            col  <= '0;
        end else if (!busy) begin
            if (i_start) begin
                busy <= 1'b1;
                col  <= '0;
            end
        end else begin
            col <= col + 1'b1;
            if (col_end) begin
                busy <= 1'b0; // column 14 goes out this cycle.
            end
        end
    end

    // column col, top row first.
    always_comb begin
        for (int r = 0; r < LINE_LEN; r++) begin
            o_line[r] = board_q[r*LINE_LEN + int'(col)];
        end
    end

    assign o_line_valid = busy;
    assign o_line_last  = busy && col_end;

    always_comb begin
        bad_cell = 1'b0;
        for (int i = 0; i < LINE_LEN*LINE_LEN; i++) begin
            if (!(board_q[i].kind inside {CELL_BLACK, CELL_WHITE, CELL_EMPTY})) begin
                bad_cell = 1'b1;
            end
        end
    end

    a_legal_board: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        busy |-> !bad_cell);

endmodule

// ==== verilog/score_accumulator.sv ====
`timescale 1ns/1ps

module score_accumulator #(
    parameter int N_WIN   = 13,
    parameter int SCORE_W = 32
) (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  score_pkg::pat_vec_t [N_WIN-1:0]     i_black_hits,
    input  score_pkg::pat_vec_t [N_WIN-1:0]     i_white_hits,
    input  logic                                i_line_valid,
    input  logic                                i_line_last,
    output logic signed [SCORE_W-1:0]           o_score,
    output logic                                o_finish
);

    import score_pkg::*;

    logic               valid_d;
    logic               last_d;
    logic [SCORE_W-1:0] black_tot;
    logic [SCORE_W-1:0] white_tot;
    logic [SCORE_W-1:0] col_black;
    logic [SCORE_W-1:0] col_white;

    function automatic logic [SCORE_W-1:0] pat_weight(int p);
        case (p)
            PAT_FIVE:                       return SCORE_W'(W_FIVE);
            PAT_OPEN_FOUR:                  return SCORE_W'(W_OPEN_FOUR);
            PAT_BLK_FOUR_O, PAT_BLK_FOUR_R: return SCORE_W'(W_BLK_FOUR);
            PAT_OPEN_THREE:                 return SCORE_W'(W_OPEN_THREE);
            default:                        return SCORE_W'(W_OPEN_TWO);
        endcase
    endfunction

    // weighted sum of this column's hits.
    always_comb begin
        col_black = '0;
        col_white = '0;
        for (int w = 0; w < N_WIN; w++) begin
            for (int p = 0; p < N_PAT; p++) begin
                if (i_black_hits[w][p]) col_black = col_black + pat_weight(p);
                if (i_white_hits[w][p]) col_white = col_white + pat_weight(p);
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            valid_d   <= 1'b0;
            last_d    <= 1'b0;
            black_tot <= '0;
            white_tot <= '0;
            o_score   <= '0;
            o_finish  <= 1'b0;
        end else begin
            valid_d  <= i_line_valid; // aligns with the matcher register.
            last_d   <= i_line_last;
            o_finish <= valid_d && last_d;
            if (valid_d && last_d) begin
                o_score   <= $signed((black_tot + col_black) - (white_tot + col_white));
                black_tot <= '0; // next board starts clean.
                white_tot <= '0;
            end else if (valid_d) begin
                black_tot <= black_tot + col_black;
                white_tot <= white_tot + col_white;
            end
        end
    end

    a_finish_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_finish |=> !o_finish);

endmodule
